//--- common/pool_pkg.sv
package pool_pkg;

  // memory word address, shared by every port
  typedef logic [11:0] addr_t;

  // every memory in the design is one byte wide
  typedef logic [7:0] word_t;

  // signed feature map value
  typedef logic signed [7:0] pixel_t;

  // word offsets inside the parameter block
  localparam addr_t PARAM_NUM_ROW     = 12'd0;
  localparam addr_t PARAM_NUM_CHANNEL = 12'd1;
  localparam addr_t PARAM_KERNEL      = 12'd2;

  // kernel is stored as the raw window width
  localparam word_t KERNEL_2 = 8'd2;
  localparam word_t KERNEL_8 = 8'd8;

  localparam pixel_t PIXEL_MIN = 8'sh80;

  typedef enum logic [1:0] {
    SEL_PARAM,
    SEL_INPUT,
    SEL_OUTPUT
  } host_sel_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD_PARAM,
    S_LOAD_INPUT,
    S_WRITE,
    S_FINISH
  } pool_state_t;

endpackage

//--- common/sp_ram_intf.sv
interface sp_ram_intf import pool_pkg::*; ();

  // access enable, write when we is also high
  logic  cs;
  logic  we;
  addr_t addr;
  word_t wdata;
  // one cycle after a read, held while cs is low
  word_t rdata;

  modport compute (
    output cs,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport memory (
    input  cs,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- hw/pool_ram.sv
module pool_ram import pool_pkg::*; #(
  parameter int DEPTH = 1024
) (
  input  logic       clk,
  sp_ram_intf.memory mem,
  input  logic       host_cs,
  input  logic       host_we,
  input  addr_t      host_addr,
  input  word_t      host_wdata,
  output word_t      host_rdata
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t ram [DEPTH];

  logic [AW-1:0] mem_idx;
  logic [AW-1:0] host_idx;

  assign mem_idx  = mem.addr[AW-1:0];
  assign host_idx = host_addr[AW-1:0];

  // compute port is written last so it wins a same-address collision
  always_ff @(posedge clk) begin
    if (host_cs && host_we) begin
      ram[host_idx] <= host_wdata;
    end
    if (mem.cs && mem.we) begin
      ram[mem_idx] <= mem.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (mem.cs && !mem.we) begin
      mem.rdata <= ram[mem_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (host_cs && !host_we) begin
      host_rdata <= ram[host_idx];
    end
  end

endmodule

//--- max_pool/max_pool.sv
module max_pool import pool_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        start,
  output logic        finish,
  sp_ram_intf.compute param_bus,
  sp_ram_intf.compute input_bus,
  sp_ram_intf.compute output_bus
);

  pool_state_t state;
  pool_state_t state_next;

  // shared by the parameter load and the window element count
  logic [6:0] cnt;

  word_t num_row;
  word_t num_channel;
  word_t kernel;

  logic [1:0] log2_k;
  logic [2:0] k_last;
  logic [6:0] win_size;
  // windows per map row
  logic [4:0] m;

  logic [2:0] kx;
  logic [2:0] ky;
  logic [4:0] col;

  addr_t n_a;
  addr_t row_jump;
  addr_t win_back;
  addr_t out_total;
  addr_t param_addr;
  addr_t in_addr;
  addr_t out_addr;

  pixel_t rd_pix;
  pixel_t max_val;

  logic param_done;
  logic win_done;
  logic last_out;

  // unsupported widths run as 2x2
  always_comb begin
    case (kernel)
      KERNEL_2: log2_k = 2'd1;
      KERNEL_8: log2_k = 2'd3;
      default:  log2_k = 2'd1;
    endcase
  end

  assign k_last   = 3'((4'd1 << log2_k) - 4'd1);
  assign win_size = 7'd1 << (2 * log2_k);
  assign m        = 5'(num_row >> log2_k);

  assign n_a      = addr_t'(num_row);
  // from the last pixel of a window row to the first of the next
  assign row_jump = n_a - addr_t'(k_last);
  // from bottom-right of a window back up to the next window's top-left
  assign win_back = addr_t'(k_last) * n_a - 12'd1;
  assign out_total = addr_t'(m) * addr_t'(m) * addr_t'(num_channel);

  assign param_done = (cnt == 7'd3);
  assign win_done   = (cnt == win_size);
  assign last_out   = (out_addr == out_total - 12'd1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      S_IDLE:       state_next = start ? S_LOAD_PARAM : S_IDLE;
      S_LOAD_PARAM: state_next = param_done ? S_LOAD_INPUT : S_LOAD_PARAM;
      S_LOAD_INPUT: state_next = win_done ? S_WRITE : S_LOAD_INPUT;
      S_WRITE:      state_next = last_out ? S_FINISH : S_LOAD_INPUT;
      S_FINISH:     state_next = S_IDLE;
      default:      state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt <= '0;
    end else begin
      case (state)
        S_LOAD_PARAM: cnt <= param_done ? '0 : cnt + 7'd1;
        S_LOAD_INPUT: cnt <= win_done ? '0 : cnt + 7'd1;
        default:      cnt <= '0;
      endcase
    end
  end

  // parameter reads go out on cnt 0..2, data returns one cycle later
  assign param_addr = addr_t'(cnt);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      num_row     <= '0;
      num_channel <= '0;
      kernel      <= '0;
    end else if (state == S_LOAD_PARAM && cnt != 7'd0) begin
      case (param_addr - 12'd1)
        PARAM_NUM_ROW:     num_row     <= param_bus.rdata;
        PARAM_NUM_CHANNEL: num_channel <= param_bus.rdata;
        PARAM_KERNEL:      kernel      <= param_bus.rdata;
        default:           ;
      endcase
    end
  end

  // window walk, one step per issued read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      in_addr <= '0;
      kx      <= '0;
      ky      <= '0;
      col     <= '0;
    end else if (state == S_IDLE && start) begin
      in_addr <= '0;
      kx      <= '0;
      ky      <= '0;
      col     <= '0;
    end else if (state == S_LOAD_INPUT && !win_done) begin
      if (kx != k_last) begin
        kx      <= kx + 3'd1;
        in_addr <= in_addr + 12'd1;
      end else if (ky != k_last) begin
        kx      <= '0;
        ky      <= ky + 3'd1;
        in_addr <= in_addr + row_jump;
      end else begin
        kx <= '0;
        ky <= '0;
        if (col != m - 5'd1) begin
          col     <= col + 5'd1;
          in_addr <= in_addr - win_back;
        end else begin
          // next band, also covers the step into the next channel
          col     <= '0;
          in_addr <= in_addr + 12'd1;
        end
      end
    end
  end

  assign rd_pix = pixel_t'(input_bus.rdata);

  // cnt 0 has no data back yet, so reseed there
  always_ff @(posedge clk) begin
    if (state == S_LOAD_INPUT) begin
      if (cnt == 7'd0) begin
        max_val <= PIXEL_MIN;
      end else if (rd_pix > max_val) begin
        max_val <= rd_pix;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_addr <= '0;
    end else if (state == S_IDLE && start) begin
      out_addr <= '0;
    end else if (state == S_WRITE) begin
      out_addr <= out_addr + 12'd1;
    end
  end

  assign param_bus.cs    = (state == S_LOAD_PARAM) && !param_done;
  assign param_bus.we    = 1'b0;
  assign param_bus.addr  = param_addr;
  assign param_bus.wdata = '0;

  assign input_bus.cs    = (state == S_LOAD_INPUT) && !win_done;
  assign input_bus.we    = 1'b0;
  assign input_bus.addr  = in_addr;
  assign input_bus.wdata = '0;

  assign output_bus.cs    = (state == S_WRITE);
  assign output_bus.we    = (state == S_WRITE);
  assign output_bus.addr  = out_addr;
  assign output_bus.wdata = word_t'(max_val);

  assign finish = (state == S_FINISH);

endmodule

//--- hw/pool_top.sv
module pool_top import pool_pkg::*; #(
  parameter int PARAM_DEPTH  = 8,
  parameter int INPUT_DEPTH  = 4096,
  parameter int OUTPUT_DEPTH = 1024
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      start,
  output logic      finish,
  input  logic      host_cs,
  input  logic      host_we,
  input  host_sel_t host_sel,
  input  addr_t     host_addr,
  input  word_t     host_wdata,
  output word_t     host_rdata
);

  sp_ram_intf param_bus ();
  sp_ram_intf input_bus ();
  sp_ram_intf output_bus ();

  logic param_host_cs;
  logic input_host_cs;
  logic output_host_cs;

  word_t param_host_rdata;
  word_t input_host_rdata;
  word_t output_host_rdata;

  // read data arrives one cycle after the request
  host_sel_t host_sel_q;

  assign param_host_cs  = host_cs && (host_sel == SEL_PARAM);
  assign input_host_cs  = host_cs && (host_sel == SEL_INPUT);
  assign output_host_cs = host_cs && (host_sel == SEL_OUTPUT);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      host_sel_q <= SEL_PARAM;
    end else if (host_cs) begin
      host_sel_q <= host_sel;
    end
  end

  always_comb begin
    case (host_sel_q)
      SEL_PARAM: host_rdata = param_host_rdata;
      SEL_INPUT: host_rdata = input_host_rdata;
      default:   host_rdata = output_host_rdata;
    endcase
  end

  pool_ram #(
    .DEPTH(PARAM_DEPTH)
  ) u_param_ram (
    .clk       (clk),
    .mem       (param_bus.memory),
    .host_cs   (param_host_cs),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(param_host_rdata)
  );

  pool_ram #(
    .DEPTH(INPUT_DEPTH)
  ) u_input_ram (
    .clk       (clk),
    .mem       (input_bus.memory),
    .host_cs   (input_host_cs),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(input_host_rdata)
  );

  pool_ram #(
    .DEPTH(OUTPUT_DEPTH)
  ) u_output_ram (
    .clk       (clk),
    .mem       (output_bus.memory),
    .host_cs   (output_host_cs),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(output_host_rdata)
  );

  max_pool u_max_pool (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .finish    (finish),
    .param_bus (param_bus.compute),
    .input_bus (input_bus.compute),
    .output_bus(output_bus.compute)
  );

endmodule

//--- testbench/tb_pool_top.sv
module tb_pool_top import pool_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CASES      = 6;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int QUIET_CYCLES   = 20;

  localparam int FILL_RANDOM  = 0;
  localparam int FILL_MIN     = 1;
  localparam int FILL_ONE_MAX = 2;

  // one row per run applied back to back
  int    case_row     [NUM_CASES] = '{8, 16, 8, 16, 4, 32};
  int    case_channel [NUM_CASES] = '{2, 1, 1, 2, 3, 1};
  word_t case_kernel  [NUM_CASES] = '{KERNEL_2, KERNEL_8, KERNEL_2, KERNEL_8, KERNEL_2, KERNEL_8};
  int    case_fill    [NUM_CASES] = '{FILL_RANDOM, FILL_RANDOM, FILL_MIN, FILL_ONE_MAX,
                                      FILL_ONE_MAX, FILL_RANDOM};

  logic      clk;
  logic      rstn;
  logic      start;
  logic      finish;
  logic      host_cs;
  logic      host_we;
  host_sel_t host_sel;
  addr_t     host_addr;
  word_t     host_wdata;
  word_t     host_rdata;

  int seed = 32'h10a1;

  // copy of the input map as written to the DUT
  pixel_t model [4096];

  pool_top uut (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .finish    (finish),
    .host_cs   (host_cs),
    .host_we   (host_we),
    .host_sel  (host_sel),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("SIMULATION FAILED");
    $display("%s", msg);
    $fatal(1, "stopped at first error");
  endtask

  task automatic write_mem(input host_sel_t sel, input addr_t addr, input word_t data);
    @(posedge clk);
    host_cs    <= 1'b1;
    host_we    <= 1'b1;
    host_sel   <= sel;
    host_addr  <= addr;
    host_wdata <= data;
  endtask

  task automatic release_host_port();
    @(posedge clk);
    host_cs <= 1'b0;
    host_we <= 1'b0;
  endtask

  // data comes back one cycle after the request
  task automatic read_mem(input host_sel_t sel, input addr_t addr, output word_t data);
    @(posedge clk);
    host_cs   <= 1'b1;
    host_we   <= 1'b0;
    host_sel  <= sel;
    host_addr <= addr;
    @(posedge clk);
    host_cs <= 1'b0;
    @(negedge clk);
    data = host_rdata;
  endtask

  task automatic expect_readback(input host_sel_t sel, input addr_t addr, input word_t exp,
                                 input string what);
    word_t got;
    read_mem(sel, addr, got);
    assert (got == exp)
    else abort_run($sformatf("ERR host_rdata %s addr %h got %h exp %h", what, addr, got, exp));
  endtask

  task automatic fill_input(input int n, input int ch, input int k, input int mode);
    int a;
    int w;
    int m;
    int spot;
    int off;
    m = n / k;
    for (int c = 0; c < ch; c++) begin
      for (int r = 0; r < n; r++) begin
        for (int x = 0; x < n; x++) begin
          a = c * n * n + r * n + x;
          case (mode)
            FILL_RANDOM: model[a] = pixel_t'($random(seed));
            FILL_MIN:    model[a] = 8'sh80;
            default: begin
              // one positive peak per window placed by window index
              w    = c * m * m + (r / k) * m + x / k;
              spot = (w * 5) % (k * k);
              off  = (r % k) * k + x % k;
              if (off == spot) begin
                model[a] = pixel_t'(1 + w % 100);
              end else begin
                model[a] = pixel_t'(-1 - (a * 7) % 120);
              end
            end
          endcase
          write_mem(SEL_INPUT, addr_t'(a), word_t'(model[a]));
        end
      end
    end
    release_host_port();
  endtask

  function automatic pixel_t window_max(input int c, input int i, input int j,
                                        input int n, input int k);
    pixel_t best;
    int     base;
    base = c * n * n + i * k * n + j * k;
    best = model[base];
    for (int r = 0; r < k; r++) begin
      for (int x = 0; x < k; x++) begin
        if (model[base + r * n + x] > best) begin
          best = model[base + r * n + x];
        end
      end
    end
    return best;
  endfunction

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_finish();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!finish) begin
      if (cycles == TIMEOUT_CYCLES) begin
        abort_run("timeout while waiting for finish");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // finish must drop after one cycle and stay low
  task automatic verify_single_finish();
    @(negedge clk);
    assert (!finish) else abort_run("finish stayed high for more than one cycle");
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (!finish) else abort_run("extra finish pulse after a single start");
    end
  endtask

  task automatic compare_outputs(input int n, input int ch, input int k);
    int     m;
    int     a;
    word_t  got;
    pixel_t want;
    m = n / k;
    for (int c = 0; c < ch; c++) begin
      for (int i = 0; i < m; i++) begin
        for (int j = 0; j < m; j++) begin
          a    = c * m * m + i * m + j;
          want = window_max(c, i, j, n, k);
          read_mem(SEL_OUTPUT, addr_t'(a), got);
          assert (pixel_t'(got) == want)
          else abort_run($sformatf("ERR output addr %h got %h exp %h", a, got, want));
        end
      end
    end
  endtask

  initial begin
    int    n;
    int    ch;
    int    last;
    word_t k;
    rstn       <= 1'b0;
    start      <= 1'b0;
    host_cs    <= 1'b0;
    host_we    <= 1'b0;
    host_sel   <= SEL_PARAM;
    host_addr  <= '0;
    host_wdata <= '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;

    // idle engine must stay quiet
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (!finish) else abort_run("finish went high without a start");
    end

    for (int t = 0; t < NUM_CASES; t++) begin
      n    = case_row[t];
      ch   = case_channel[t];
      k    = case_kernel[t];
      last = n * n * ch - 1;
      write_mem(SEL_PARAM, PARAM_NUM_ROW, word_t'(n));
      write_mem(SEL_PARAM, PARAM_NUM_CHANNEL, word_t'(ch));
      write_mem(SEL_PARAM, PARAM_KERNEL, k);
      release_host_port();
      expect_readback(SEL_PARAM, PARAM_NUM_ROW, word_t'(n), "param");
      expect_readback(SEL_PARAM, PARAM_NUM_CHANNEL, word_t'(ch), "param");
      expect_readback(SEL_PARAM, PARAM_KERNEL, k, "param");
      fill_input(n, ch, int'(k), case_fill[t]);
      expect_readback(SEL_INPUT, '0, word_t'(model[0]), "input");
      expect_readback(SEL_INPUT, addr_t'(last), word_t'(model[last]), "input");
      pulse_start();
      wait_finish();
      verify_single_finish();
      compare_outputs(n, ch, int'(k));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- project.f
common/pool_pkg.sv
common/sp_ram_intf.sv
hw/pool_ram.sv
max_pool/max_pool.sv
hw/pool_top.sv
testbench/tb_pool_top.sv

//--- run.sh
#!/bin/sh
# build and run the max-pool testbench with Verilator
# exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    --top-module tb_pool_top \
    -f project.f \
    -o sim_tb &&
  ./obj_dir/sim_tb ||
  exit 1
